/* ros2_glue_cfg.svh */
`ifndef ROS2_GLUE_CFG_SVH
`define ROS2_GLUE_CFG_SVH

// stream FIFO depths.
`define RX_FIFO_DEPTH 16
`define TX_FIFO_DEPTH 16

// udp buffer geometry.
`define BUF_ADDR_W 6
`define BUF_DATA_W 32

// transmit release period is 2**N + 1 cycles.
`define HOST_TX_PERIOD_LOG2 6

// led size classes.
`define LED_RED_MAX 10
`define LED_GREEN_MAX 20

`endif

/* ros2_glue_pkg.sv */
`default_nettype none

`include "ros2_glue_cfg.svh"

package ros2_glue_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [`BUF_ADDR_W-1:0] buf_addr_t;
    typedef logic [`BUF_DATA_W-1:0] buf_word_t;

    typedef enum logic {
        OWNER_IP  = 1'b0,
        OWNER_CPU = 1'b1
    } owner_e;

    typedef enum logic [1:0] {
        GRANT_NONE = 2'b00,
        GRANT_IP   = 2'b01,
        GRANT_CPU  = 2'b10
    } app_grant_e;

    // single-cycle strobes from one requester.
    typedef struct packed {
        logic req;
        logic rel;
    } arb_ctl_t;

    typedef struct packed {
        logic      we;
        buf_addr_t addr;
        buf_word_t wdata;
    } rxbuf_wr_t;

    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } led_t;

endpackage

`default_nettype wire

/* byte_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module byte_fifo
    import ros2_glue_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  logic  clk_int,
    input  logic  rst_int,
    input  logic  push,
    input  byte_t din,
    output logic  full,
    input  logic  pop,
    output byte_t dout,
    output logic  empty
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);
    localparam logic [AW-1:0] LAST = AW'(DEPTH - 1);

    byte_t mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic do_push;
    logic do_pop;

    // overflow and underflow are dropped.
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == CW'(DEPTH));

    // head is visible while not empty.
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk_int) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk_int) begin
        if (rst_int) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    count_in_range: assert property (@(posedge clk_int) disable iff (rst_int)
        count <= CW'(DEPTH));

    not_full_and_empty: assert property (@(posedge clk_int) disable iff (rst_int)
        !(full && empty));

endmodule

`default_nettype wire

/* app_data_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module app_data_arbiter
    import ros2_glue_pkg::*;
(
    input  logic     clk_int,
    input  logic     rst_int,
    input  arb_ctl_t ip,
    input  arb_ctl_t cpu,
    output logic     ip_grant,
    output logic     cpu_grant
);

    app_grant_e state;

    always_ff @(posedge clk_int) begin
        if (rst_int) begin
            state <= GRANT_NONE;
        end else begin
            case (state)
                GRANT_NONE: begin
                    // ip wins a tie.
                    if (ip.req) begin
                        state <= GRANT_IP;
                    end else if (cpu.req) begin
                        state <= GRANT_CPU;
                    end
                end
                GRANT_IP: begin
                    if (ip.rel) begin
                        state <= GRANT_NONE;
                    end
                end
                GRANT_CPU: begin
                    if (cpu.rel) begin
                        state <= GRANT_NONE;
                    end
                end
                default: begin
                    state <= GRANT_NONE;
                end
            endcase
        end
    end

    assign ip_grant  = (state == GRANT_IP);
    assign cpu_grant = (state == GRANT_CPU);

    grants_exclusive: assert property (@(posedge clk_int) disable iff (rst_int)
        !(ip_grant && cpu_grant));

endmodule

`default_nettype wire

/* buf_owner.sv */
`timescale 1ns/1ns
`default_nettype none

module buf_owner
    import ros2_glue_pkg::*;
#(
    parameter owner_e RESET_OWNER = OWNER_IP
) (
    input  logic clk_int,
    input  logic rst_int,
    input  logic ip_rel,
    input  logic cpu_rel,
    output logic ip_grant,
    output logic cpu_grant
);

    owner_e owner;

    // a release from the side that does not own the buffer is ignored.
    always_ff @(posedge clk_int) begin
        if (rst_int) begin
            owner <= RESET_OWNER;
        end else begin
            case (owner)
                OWNER_IP: begin
                    if (ip_rel) begin
                        owner <= OWNER_CPU;
                    end
                end
                OWNER_CPU: begin
                    if (cpu_rel) begin
                        owner <= OWNER_IP;
                    end
                end
                default: begin
                    owner <= RESET_OWNER;
                end
            endcase
        end
    end

    assign ip_grant  = (owner == OWNER_IP);
    assign cpu_grant = (owner == OWNER_CPU);

    one_owner: assert property (@(posedge clk_int) disable iff (rst_int)
        $onehot({ip_grant, cpu_grant}));

endmodule

`default_nettype wire

/* host_agent.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ros2_glue_cfg.svh"

module host_agent
    import ros2_glue_pkg::*;
(
    input  logic      clk_int,
    input  logic      rst_int,
    input  logic      rxbuf_cpu_grant,
    output logic      rxbuf_cpu_rel,
    input  rxbuf_wr_t rxbuf_wr,
    output logic      txbuf_cpu_rel,
    input  buf_addr_t txbuf_addr,
    output buf_word_t txbuf_rdata,
    output led_t      leds
);

    localparam int CNT_W = `HOST_TX_PERIOD_LOG2 + 1;
    localparam int SIZE_W = 16;
    localparam logic [SIZE_W-1:0] RED_MAX = SIZE_W'(`LED_RED_MAX);
    localparam logic [SIZE_W-1:0] GREEN_MAX = SIZE_W'(`LED_GREEN_MAX);

    logic [CNT_W-1:0] tx_cnt;
    logic [SIZE_W-1:0] last_size;

    // periodic release of the transmit buffer.
    always_ff @(posedge clk_int) begin
        if (rst_int) begin
            tx_cnt        <= '0;
            txbuf_cpu_rel <= 1'b0;
        end else if (tx_cnt[CNT_W-1]) begin
            tx_cnt        <= '0;
            txbuf_cpu_rel <= 1'b1;
        end else begin
            tx_cnt        <= tx_cnt + 1'b1;
            txbuf_cpu_rel <= 1'b0;
        end
    end

    // fixed outgoing message.
    always_ff @(posedge clk_int) begin
        case (txbuf_addr)
            buf_addr_t'(0): txbuf_rdata <= 32'h0a01a8c0;
            buf_addr_t'(1): txbuf_rdata <= 32'h045704d2;
            buf_addr_t'(2): txbuf_rdata <= 32'h00000007;
            buf_addr_t'(3): txbuf_rdata <= 32'h626f6f66;
            buf_addr_t'(4): txbuf_rdata <= 32'h000a7261;
            default:        txbuf_rdata <= '0;
        endcase
    end

    // hand the receive buffer straight back and keep the size word.
    always_ff @(posedge clk_int) begin
        if (rst_int) begin
            rxbuf_cpu_rel <= 1'b0;
            last_size     <= '0;
        end else begin
            rxbuf_cpu_rel <= rxbuf_cpu_grant;
            if (rxbuf_wr.we && rxbuf_wr.addr == buf_addr_t'(1)) begin
                last_size <= rxbuf_wr.wdata[`BUF_DATA_W-1 -: SIZE_W];
            end
        end
    end

    always_comb begin
        leds.r = (last_size != '0) && (last_size <= RED_MAX);
        leds.g = (last_size > RED_MAX) && (last_size <= GREEN_MAX);
        leds.b = (last_size > GREEN_MAX);
    end

    // lamps move only after a size write.
    leds_hold: assert property (@(posedge clk_int) disable iff (rst_int)
        !(rxbuf_wr.we && rxbuf_wr.addr == buf_addr_t'(1)) |=> $stable(leds));

endmodule

`default_nettype wire

/* ros2_glue_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ros2_glue_cfg.svh"

module ros2_glue_top
    import ros2_glue_pkg::*;
(
    input  logic      clk_int,
    input  logic      rst_int,

    input  logic      rx_push,
    input  byte_t     rx_din,
    output logic      rx_full,
    input  logic      rx_pop,
    output byte_t     rx_dout,
    output logic      rx_empty,

    input  logic      tx_push,
    input  byte_t     tx_din,
    output logic      tx_full,
    input  logic      tx_pop,
    output byte_t     tx_dout,
    output logic      tx_empty,

    input  arb_ctl_t  app_ip,
    input  arb_ctl_t  app_cpu,
    output logic      app_ip_grant,
    output logic      app_cpu_grant,

    input  logic      rxbuf_ip_rel,
    input  rxbuf_wr_t rxbuf_wr,
    output logic      rxbuf_ip_grant,
    output logic      rxbuf_cpu_grant,

    input  logic      txbuf_ip_rel,
    input  buf_addr_t txbuf_addr,
    output buf_word_t txbuf_rdata,
    output logic      txbuf_ip_grant,
    output logic      txbuf_cpu_grant,

    output led_t      leds
);

    logic rxbuf_cpu_rel;
    logic txbuf_cpu_rel;

    byte_fifo #(
        .DEPTH(`RX_FIFO_DEPTH)
    ) rx_fifo_i (
        .clk_int (clk_int),
        .rst_int (rst_int),
        .push    (rx_push),
        .din     (rx_din),
        .full    (rx_full),
        .pop     (rx_pop),
        .dout    (rx_dout),
        .empty   (rx_empty)
    );

    byte_fifo #(
        .DEPTH(`TX_FIFO_DEPTH)
    ) tx_fifo_i (
        .clk_int (clk_int),
        .rst_int (rst_int),
        .push    (tx_push),
        .din     (tx_din),
        .full    (tx_full),
        .pop     (tx_pop),
        .dout    (tx_dout),
        .empty   (tx_empty)
    );

    app_data_arbiter app_data_arbiter_i (
        .clk_int   (clk_int),
        .rst_int   (rst_int),
        .ip        (app_ip),
        .cpu       (app_cpu),
        .ip_grant  (app_ip_grant),
        .cpu_grant (app_cpu_grant)
    );

    // receive buffer starts with the protocol engine.
    buf_owner #(
        .RESET_OWNER(OWNER_IP)
    ) rxbuf_owner_i (
        .clk_int   (clk_int),
        .rst_int   (rst_int),
        .ip_rel    (rxbuf_ip_rel),
        .cpu_rel   (rxbuf_cpu_rel),
        .ip_grant  (rxbuf_ip_grant),
        .cpu_grant (rxbuf_cpu_grant)
    );

    // transmit buffer starts with the host.
    buf_owner #(
        .RESET_OWNER(OWNER_CPU)
    ) txbuf_owner_i (
        .clk_int   (clk_int),
        .rst_int   (rst_int),
        .ip_rel    (txbuf_ip_rel),
        .cpu_rel   (txbuf_cpu_rel),
        .ip_grant  (txbuf_ip_grant),
        .cpu_grant (txbuf_cpu_grant)
    );

    host_agent host_agent_i (
        .clk_int         (clk_int),
        .rst_int         (rst_int),
        .rxbuf_cpu_grant (rxbuf_cpu_grant),
        .rxbuf_cpu_rel   (rxbuf_cpu_rel),
        .rxbuf_wr        (rxbuf_wr),
        .txbuf_cpu_rel   (txbuf_cpu_rel),
        .txbuf_addr      (txbuf_addr),
        .txbuf_rdata     (txbuf_rdata),
        .leds            (leds)
    );

endmodule

`default_nettype wire

/* tb_checker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ros2_glue_cfg.svh"

module tb_checker
    import ros2_glue_pkg::*;
(
    input  logic      clk_int,
    input  logic      rst_int,
    input  logic      rx_push,
    input  byte_t     rx_din,
    input  logic      rx_full,
    input  logic      rx_pop,
    input  byte_t     rx_dout,
    input  logic      rx_empty,
    input  logic      tx_push,
    input  byte_t     tx_din,
    input  logic      tx_full,
    input  logic      tx_pop,
    input  byte_t     tx_dout,
    input  logic      tx_empty,
    input  arb_ctl_t  app_ip,
    input  arb_ctl_t  app_cpu,
    input  logic      app_ip_grant,
    input  logic      app_cpu_grant,
    input  logic      rxbuf_ip_rel,
    input  rxbuf_wr_t rxbuf_wr,
    input  logic      rxbuf_ip_grant,
    input  logic      rxbuf_cpu_grant,
    input  logic      txbuf_ip_rel,
    input  buf_addr_t txbuf_addr,
    input  buf_word_t txbuf_rdata,
    input  logic      txbuf_ip_grant,
    input  logic      txbuf_cpu_grant,
    input  led_t      leds,
    output int        error_count,
    output int        check_count
);

    localparam int TX_PERIOD = (1 << `HOST_TX_PERIOD_LOG2) + 1;

    byte_t rx_q [$];
    byte_t tx_q [$];
    app_grant_e arb_s;
    owner_e rx_owner;
    owner_e rx_next;
    logic rx_rel;
    owner_e tx_owner;
    int edges;
    buf_addr_t prev_addr;
    logic [15:0] last_size;
    int cpu_run;
    int errors = 0;
    int checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    // ip wins a tie, a grant holds until its own release.
    function automatic app_grant_e arb_next(input app_grant_e s, input arb_ctl_t ip,
                                            input arb_ctl_t cpu);
        if (s == GRANT_NONE) begin
            return ip.req ? GRANT_IP : (cpu.req ? GRANT_CPU : GRANT_NONE);
        end
        if ((s == GRANT_IP && ip.rel) || (s == GRANT_CPU && cpu.rel)) begin
            return GRANT_NONE;
        end
        return s;
    endfunction

    function automatic owner_e owner_next(input owner_e o, input logic ip_rel,
                                          input logic cpu_rel);
        if (o == OWNER_IP && ip_rel) begin
            return OWNER_CPU;
        end
        if (o == OWNER_CPU && cpu_rel) begin
            return OWNER_IP;
        end
        return o;
    endfunction

    function automatic logic period_hit(input int n);
        return (n > 0) && (n % TX_PERIOD == 0);
    endfunction

    function automatic buf_word_t tx_word(input buf_addr_t a);
        case (a)
            buf_addr_t'(0): return 32'h0a01a8c0;
            buf_addr_t'(1): return 32'h045704d2;
            buf_addr_t'(2): return 32'h00000007;
            buf_addr_t'(3): return 32'h626f6f66;
            buf_addr_t'(4): return 32'h000a7261;
            default:        return '0;
        endcase
    endfunction

    function automatic led_t size_leds(input logic [15:0] size);
        led_t l;
        l = '0;
        if (size == 0) begin
            l = '0;
        end else if (size <= `LED_RED_MAX) begin
            l.r = 1'b1;
        end else if (size <= `LED_GREEN_MAX) begin
            l.g = 1'b1;
        end else begin
            l.b = 1'b1;
        end
        return l;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error @ %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // compare one FIFO against its queue, then apply this edge.
    task automatic fifo_cycle(input string name, ref byte_t q[$], input int depth,
                              input logic push, input byte_t din, input logic pop,
                              input logic full, input byte_t dout, input logic empty);
        logic push_ok;
        logic pop_ok;
        check_value({name, " empty"}, 32'(empty), 32'(q.size() == 0));
        check_value({name, " full"}, 32'(full), 32'(q.size() == depth));
        if (q.size() != 0) begin
            check_value({name, " dout"}, 32'(dout), 32'(q[0]));
        end
        push_ok = push && (q.size() < depth);
        pop_ok = pop && (q.size() != 0);
        if (pop_ok) begin
            void'(q.pop_front());
        end
        if (push_ok) begin
            q.push_back(din);
        end
    endtask

    always @(posedge clk_int) begin
        if (rst_int) begin
            rx_q.delete();
            tx_q.delete();
            arb_s = GRANT_NONE;
            rx_owner = OWNER_IP;
            rx_rel = 1'b0;
            tx_owner = OWNER_CPU;
            edges = 0;
            last_size = '0;
            cpu_run = 0;
        end else begin
            check_value("app_ip_grant", 32'(app_ip_grant), 32'(arb_s == GRANT_IP));
            check_value("app_cpu_grant", 32'(app_cpu_grant), 32'(arb_s == GRANT_CPU));
            check_value("rxbuf_ip_grant", 32'(rxbuf_ip_grant), 32'(rx_owner == OWNER_IP));
            check_value("rxbuf_cpu_grant", 32'(rxbuf_cpu_grant), 32'(rx_owner == OWNER_CPU));
            check_value("txbuf_ip_grant", 32'(txbuf_ip_grant), 32'(tx_owner == OWNER_IP));
            check_value("txbuf_cpu_grant", 32'(txbuf_cpu_grant), 32'(tx_owner == OWNER_CPU));
            check_value("txbuf_rdata", txbuf_rdata, tx_word(prev_addr));
            check_value("leds", 32'(leds), 32'(size_leds(last_size)));
            // host must hand the receive buffer back after two cycles.
            if (rxbuf_cpu_grant) begin
                cpu_run++;
            end else if (cpu_run != 0) begin
                check_value("rxbuf cpu hold cycles", cpu_run, 2);
                cpu_run = 0;
            end
            fifo_cycle("rx", rx_q, `RX_FIFO_DEPTH, rx_push, rx_din, rx_pop,
                       rx_full, rx_dout, rx_empty);
            fifo_cycle("tx", tx_q, `TX_FIFO_DEPTH, tx_push, tx_din, tx_pop,
                       tx_full, tx_dout, tx_empty);
            arb_s = arb_next(arb_s, app_ip, app_cpu);
            rx_next = owner_next(rx_owner, rxbuf_ip_rel, rx_rel);
            rx_rel = (rx_owner == OWNER_CPU);
            rx_owner = rx_next;
            tx_owner = owner_next(tx_owner, txbuf_ip_rel, period_hit(edges));
            edges++;
            if (rxbuf_wr.we && rxbuf_wr.addr == buf_addr_t'(1)) begin
                last_size = rxbuf_wr.wdata[31:16];
            end
        end
        prev_addr = txbuf_addr;
    end

endmodule

`default_nettype wire

/* tb_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_top
    import ros2_glue_pkg::*;
();

    localparam int CLK_NS = 8;
    localparam int RESET_CYCLES = 8;
    localparam int PHASE_CYCLES = 200;
    localparam int MIX_CYCLES = 3 * PHASE_CYCLES;
    localparam int LED_SIZES = 7;
    localparam int LED_CYCLES = 4 * LED_SIZES;
    localparam int TAIL_CYCLES = 4;
    localparam int TIMEOUT_NS =
        (RESET_CYCLES + MIX_CYCLES + LED_CYCLES + TAIL_CYCLES + 100) * CLK_NS;

    logic clk_int = 1'b0;
    logic rst_int;
    logic rx_push;
    byte_t rx_din;
    logic rx_full;
    logic rx_pop;
    byte_t rx_dout;
    logic rx_empty;
    logic tx_push;
    byte_t tx_din;
    logic tx_full;
    logic tx_pop;
    byte_t tx_dout;
    logic tx_empty;
    arb_ctl_t app_ip;
    arb_ctl_t app_cpu;
    logic app_ip_grant;
    logic app_cpu_grant;
    logic rxbuf_ip_rel;
    rxbuf_wr_t rxbuf_wr;
    logic rxbuf_ip_grant;
    logic rxbuf_cpu_grant;
    logic txbuf_ip_rel;
    buf_addr_t txbuf_addr;
    buf_word_t txbuf_rdata;
    logic txbuf_ip_grant;
    logic txbuf_cpu_grant;
    led_t leds;
    int error_count;
    int check_count;

    logic [16:0] lfsr = 17'd66178;
    int sweep_idx;

    always #(CLK_NS / 2) clk_int = ~clk_int;

    ros2_glue_top dut_i (.*);

    tb_checker chk_i (.*);

    // x^17 + x^14 + 1.
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[16] ^ lfsr[13];
        lfsr = {lfsr[15:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] take(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // high with a chance of weight in four.
    function automatic logic biased_bit(input int weight);
        return take(2) < weight;
    endfunction

    task automatic clear_strobes();
        rx_push = 1'b0;
        rx_pop = 1'b0;
        tx_push = 1'b0;
        tx_pop = 1'b0;
        app_ip = '0;
        app_cpu = '0;
        rxbuf_ip_rel = 1'b0;
        rxbuf_wr.we = 1'b0;
    endtask

    // mode 0 fills the FIFOs, mode 1 drains them, mode 2 is balanced.
    task automatic drive_mix(input int mode);
        int push_w;
        push_w = (mode == 0) ? 3 : ((mode == 1) ? 1 : 2);
        rx_push = biased_bit(push_w);
        rx_pop = biased_bit(4 - push_w);
        rx_din = byte_t'(take(8));
        tx_push = biased_bit(push_w);
        tx_pop = biased_bit(4 - push_w);
        tx_din = byte_t'(take(8));
        app_ip.req = biased_bit(1);
        app_ip.rel = biased_bit(1);
        app_cpu.req = biased_bit(1);
        app_cpu.rel = biased_bit(1);
        rxbuf_ip_rel = biased_bit(1);
        rxbuf_wr.we = biased_bit(1);
        rxbuf_wr.addr = buf_addr_t'(take(6));
        rxbuf_wr.wdata = take(32);
    endtask

    // ip reads words 0 to 7 while it owns the transmit buffer, then releases it.
    task automatic drive_tx();
        if (txbuf_ip_grant && sweep_idx < 8) begin
            txbuf_addr = buf_addr_t'(sweep_idx);
            txbuf_ip_rel = 1'b0;
            sweep_idx++;
        end else if (txbuf_ip_grant) begin
            txbuf_ip_rel = 1'b1;
            sweep_idx = 0;
        end else begin
            txbuf_ip_rel = (take(3) == 0);
            sweep_idx = 0;
        end
    endtask

    task automatic next_cycle();
        @(negedge clk_int);
        clear_strobes();
        drive_tx();
    endtask

    task automatic write_size(input logic [15:0] size);
        next_cycle();
        rxbuf_wr.we = 1'b1;
        rxbuf_wr.addr = buf_addr_t'(1);
        rxbuf_wr.wdata = {size, 16'(take(16))};
        // bit 1 set, so never the size word.
        next_cycle();
        rxbuf_wr.we = 1'b1;
        rxbuf_wr.addr = buf_addr_t'(take(6)) | buf_addr_t'(2);
        rxbuf_wr.wdata = take(32);
        repeat (2) next_cycle();
    endtask

    initial begin
        logic [15:0] sizes [LED_SIZES];
        rst_int = 1'b1;
        clear_strobes();
        rx_din = '0;
        tx_din = '0;
        rxbuf_wr = '0;
        txbuf_addr = '0;
        txbuf_ip_rel = 1'b0;
        sweep_idx = 0;
        repeat (RESET_CYCLES) @(negedge clk_int);
        rst_int = 1'b0;
        for (int m = 0; m < 3; m++) begin
            repeat (PHASE_CYCLES) begin
                @(negedge clk_int);
                drive_mix(m);
                drive_tx();
            end
        end
        sizes = '{16'd0, 16'd1, 16'd10, 16'd11, 16'd20, 16'd21, 16'(take(16))};
        foreach (sizes[i]) begin
            write_size(sizes[i]);
        end
        repeat (TAIL_CYCLES) next_cycle();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* ros2_glue.f */
+incdir+.
ros2_glue_pkg.sv
byte_fifo.sv
app_data_arbiter.sv
buf_owner.sv
host_agent.sv
ros2_glue_top.sv
tb_checker.sv
tb_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f ros2_glue.f -o tb_sim
status=0
./obj_dir/tb_sim > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "Test failures found" sim.log; then
    echo "simulation reported failures"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
echo "simulation clean"
